// ==== filelist.f ====
hdl/dcore_const_pkg.sv
hdl/dcore_types_pkg.sv
hdl/dcore_ctrl.sv
hdl/adc_unfold.sv
hdl/mm_cdr_loop.sv
hdl/pi_code_map.sv
hdl/prbs_bist_gen.sv
hdl/prbs_checker.sv
hdl/dcore_top.sv
verification/dcore_asserts.sv
verification/dcore_tb.sv

// ==== verification/dcore_tb.sv ====
module dcore_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import dcore_const_pkg::*;
    import dcore_types_pkg::*;

    localparam int n_rows     = 6;
    localparam int max_cyc    = 512;
    localparam int rst_cycles = 10;
    localparam int idle_words = 4;
    localparam int tail_words = 8;

    typedef struct packed {
        prbs_src_e   src;
        logic [3:0]  inj;
        logic [15:0] seed;
        logic [7:0]  cycles;
        logic [7:0]  exp_err;
        logic [15:0] exp_tot;
    } row_t;

    // source, flips, lfsr seed (0 keeps running), words, error and bit deltas
    localparam row_t rows [n_rows] = '{
        '{src_bist, 4'd0, 16'd46655, 8'd10, 8'd0, 16'd144},
        '{src_bist, 4'd2, 16'd0,     8'd10, 8'd6, 16'd144},
        '{src_adc,  4'd0, 16'd0,     8'd12, 8'd0, 16'd176},
        '{src_adc,  4'd3, 16'd0,     8'd12, 8'd9, 16'd176},
        '{src_bist, 4'd1, 16'd0,     8'd8,  8'd3, 16'd112},
        '{src_adc,  4'd1, 16'd0,     8'd8,  8'd3, 16'd112}
    };

    logic        clk_adc;
    logic        cdr_rstb;
    adc_word_t   adc_word_i;
    dcore_cfg_t  cfg_i;
    logic        inj_err_i;
    logic        ctl_valid_o;
    pi_ctl_t     pi_ctl_o;
    prbs_stats_t prbs_stats_o;

    int          cyc = 0;
    int          checks = 0;
    int          errors = 0;
    int          rst_done = -1;
    logic [15:0] lfsr = 16'd46655;
    logic [6:0]  prbs_sr = 7'h7f;
    logic [8:0]  phase = '0;
    int          prev_c = 0;
    int          prev_d = -1;
    prbs_src_e   last_src = src_bist;
    pi_ctl_t     exp_pi [max_cyc];
    bit          exp_set [max_cyc];
    prbs_stats_t stats_hist [max_cyc];
    int          row_start [n_rows];

    dcore_top UUT (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .adc_word_i  (adc_word_i),
        .cfg_i       (cfg_i),
        .inj_err_i   (inj_err_i),
        .ctl_valid_o (ctl_valid_o),
        .pi_ctl_o    (pi_ctl_o),
        .prbs_stats_o(prbs_stats_o)
    );

    initial begin
        clk_adc = 1'b0;
        forever #10 clk_adc = ~clk_adc;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s cycle %0d got %h expected %h", name, cyc, got, exp);
        end
    endtask

    // galois form, taps 16,14,13,11
    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic draw_bit(output logic b);
        b    = lfsr[0];
        lfsr = galois_step(lfsr);
    endtask

    // x^7 + x^6 + 1, sr[0] newest
    task automatic prbs_bit(output logic b);
        b       = prbs_sr[6] ^ prbs_sr[5];
        prbs_sr = {prbs_sr[5:0], b};
    endtask

    function automatic pi_ctl_t map_phase(input logic [8:0] ph);
        pi_ctl_t m;
        int      s;
        for (int j = 0; j < n_out; j++) begin
            s         = (int'(cfg_i.max_sel[j]) + 1) * scale_step - 1;
            m.code[j] = 9'((int'(ph) % s + int'(cfg_i.pi_offset[j])) & 511);
        end
        return m;
    endfunction

    // reference MM detector and integrator
    task automatic model_word(input adc_word_t w);
        int sum;
        int c;
        int d;
        sum = 0;
        for (int k = 0; k < n_ti; k++) begin
            c      = w.sign[k] ? int'(w.mag[k]) : -int'(w.mag[k]);
            d      = w.sign[k] ? 1 : -1;
            sum    = sum + prev_d * c - d * prev_c;
            prev_c = c;
            prev_d = d;
        end
        phase = 9'((int'(phase) + (sum >>> cfg_i.loop_shift)) & 511);
    endtask

    // sample 1 ns after the edge, return 2 ns after it
    task automatic next_cycle();
        @(posedge clk_adc);
        cyc++;
        #1;
        stats_hist[cyc] = prbs_stats_o;
        if (exp_set[cyc]) begin
            check_value("pi_ctl_o", pi_ctl_o, exp_pi[cyc]);
        end
        if (rst_done < 0) begin
            check_value("ctl_valid_o", ctl_valid_o, 0);
            check_value("prbs_stats_o", prbs_stats_o, 64'h0);
        end else begin
            check_value("ctl_valid_o", ctl_valid_o, cyc >= rst_done + 32);
        end
        #1;
    endtask

    // checker samples the source one cycle after the word
    task automatic apply_word(input adc_word_t w, input prbs_src_e src, input logic inj);
        adc_word_i     = w;
        inj_err_i      = inj;
        cfg_i.prbs_src = last_src;
        last_src       = src;
        model_word(w);
        exp_pi[cyc+3]  = map_phase(phase);
        exp_set[cyc+3] = 1'b1;
    endtask

    task automatic build_word(input prbs_src_e src, output adc_word_t w);
        logic b;
        for (int k = 0; k < n_ti; k++) begin
            for (int i = 0; i < n_adc; i++) begin
                draw_bit(b);
                w.mag[k][i] = b;
            end
            if (src == src_adc) begin
                prbs_bit(b);
            end else begin
                draw_bit(b);
            end
            w.sign[k] = b;
        end
    endtask

    initial begin
        int lim;
        lim = rst_cycles + 32 + idle_words + tail_words + 100;
        for (int r = 0; r < n_rows; r++) begin
            lim += rows[r].cycles;
        end
        wait (cyc >= lim);
        $display("timeout: run did not finish within %0d cycles", lim);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        adc_word_t w;
        logic      flip;
        int        s;
        int        e;
        int        afail;
        cdr_rstb          = 1'b0;
        adc_word_i        = '0;
        inj_err_i         = 1'b0;
        cfg_i             = '0;
        cfg_i.loop_shift  = 4'd3;
        cfg_i.prbs_src    = src_bist;
        cfg_i.max_sel[0]  = 4'd15;
        cfg_i.max_sel[1]  = 4'd7;
        cfg_i.max_sel[2]  = 4'd3;
        cfg_i.max_sel[3]  = 4'd0;
        cfg_i.pi_offset[0] = 9'h1a0;
        cfg_i.pi_offset[1] = 9'h005;
        cfg_i.pi_offset[2] = 9'h100;
        cfg_i.pi_offset[3] = 9'h1ff;
        for (int i = 1; i <= 3; i++) begin
            exp_pi[i]  = map_phase(9'd0);
            exp_set[i] = 1'b1;
        end

        for (int i = 0; i < rst_cycles; i++) begin
            next_cycle();
            apply_word('0, src_bist, 1'b0);
        end
        cdr_rstb = 1'b1;
        rst_done = cyc;
        while (ctl_valid_o !== 1'b1) begin
            next_cycle();
            apply_word('0, src_bist, 1'b0);
        end
        for (int i = 0; i < idle_words; i++) begin
            next_cycle();
            apply_word('0, src_bist, 1'b0);
        end

        ////////////////////////////////////////
        // stimulus table
        ////////////////////////////////////////
        for (int r = 0; r < n_rows; r++) begin
            if (rows[r].seed != 0) begin
                lfsr = rows[r].seed;
            end
            for (int n = 0; n < rows[r].cycles; n++) begin
                build_word(rows[r].src, w);
                // isolated flips on even words, never the first or last
                flip = (n >= 2) && (n % 2 == 0) && (n / 2 <= rows[r].inj);
                if (flip && rows[r].src == src_adc) begin
                    w.sign[5] = ~w.sign[5];
                end
                next_cycle();
                if (n == 0) begin
                    row_start[r] = cyc;
                end
                apply_word(w, rows[r].src, flip && rows[r].src == src_bist);
            end
        end
        for (int i = 0; i < tail_words; i++) begin
            next_cycle();
            apply_word('0, src_bist, 1'b0);
        end

        // stats lag three edges, first word of each row is history only
        for (int r = 0; r < n_rows; r++) begin
            s = row_start[r];
            e = s + rows[r].cycles;
            check_value("err_count delta",
                        stats_hist[e+2].err_count - stats_hist[s+3].err_count,
                        rows[r].exp_err);
            check_value("total_count delta",
                        stats_hist[e+2].total_count - stats_hist[s+3].total_count,
                        rows[r].exp_tot);
        end

        afail = UUT.ctrl_i.ctrl_checks.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, afail);
        if (errors == 0 && afail == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/dcore_asserts.sv ====
module dcore_asserts #(
    parameter int settle_cycles = 32
) (
    input logic clk_adc,
    input logic cdr_rstb,
    input logic ctl_valid_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench at the end of the run
    int fail_count = 0;

    // valid is sticky until the next reset
    property valid_holds;
        @(posedge clk_adc) disable iff (!cdr_rstb) ctl_valid_o |=> ctl_valid_o;
    endproperty

    // valid comes up exactly settle_cycles edges after reset release
    property valid_on_time;
        @(posedge clk_adc) disable iff (!cdr_rstb)
            $rose(ctl_valid_o) |->
                $past(cdr_rstb, settle_cycles) && !$past(cdr_rstb, settle_cycles + 1);
    endproperty

    property low_in_reset;
        @(posedge clk_adc) !cdr_rstb |-> !ctl_valid_o;
    endproperty

    valid_holds_a: assert property (valid_holds)
        else begin fail_count++; $error("ctl_valid_o fell outside reset"); end
    valid_time_a: assert property (valid_on_time)
        else begin fail_count++; $error("ctl_valid_o rose at the wrong cycle"); end
    reset_a: assert property (low_in_reset)
        else begin fail_count++; $error("ctl_valid_o high during reset"); end

endmodule

bind dcore_ctrl dcore_asserts #(.settle_cycles(settle_cycles)) ctrl_checks (.*);

// ==== hdl/dcore_top.sv ====
module dcore_top #(
    parameter int settle_cycles = 32,
    parameter int count_width   = 32
) (
    input  logic                          clk_adc,
    input  logic                          cdr_rstb,
    input  dcore_types_pkg::adc_word_t    adc_word_i,
    input  dcore_types_pkg::dcore_cfg_t   cfg_i,
    input  logic                          inj_err_i,
    output logic                          ctl_valid_o,
    output dcore_types_pkg::pi_ctl_t      pi_ctl_o,
    output dcore_types_pkg::prbs_stats_t  prbs_stats_o
);
    import dcore_const_pkg::*;
    import dcore_types_pkg::*;

    logic             loop_en;
    logic             check_en;
    code_word_t       code_word;
    logic [n_pi-1:0]  phase;
    logic [n_ti-1:0]  bist_bits;

    dcore_ctrl #(
        .settle_cycles(settle_cycles)
    ) ctrl_i (
        .clk_adc    (clk_adc),
        .cdr_rstb   (cdr_rstb),
        .ctl_valid_o(ctl_valid_o),
        .loop_en_o  (loop_en),
        .check_en_o (check_en)
    );

    ////////////////////////////////////////
    // CDR path
    ////////////////////////////////////////

    adc_unfold unfold_i (
        .clk_adc    (clk_adc),
        .cdr_rstb   (cdr_rstb),
        .adc_word_i (adc_word_i),
        .code_word_o(code_word)
    );

    mm_cdr_loop cdr_i (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .code_word_i (code_word),
        .loop_en_i   (loop_en),
        .loop_shift_i(cfg_i.loop_shift),
        .phase_o     (phase)
    );

    pi_code_map pi_map_i (
        .clk_adc    (clk_adc),
        .cdr_rstb   (cdr_rstb),
        .phase_i    (phase),
        .max_sel_i  (cfg_i.max_sel),
        .pi_offset_i(cfg_i.pi_offset),
        .pi_ctl_o   (pi_ctl_o)
    );

    ////////////////////////////////////////
    // BIST
    ////////////////////////////////////////

    prbs_bist_gen bist_gen_i (
        .clk_adc    (clk_adc),
        .cdr_rstb   (cdr_rstb),
        .inj_err_i  (inj_err_i),
        .bist_bits_o(bist_bits)
    );

    prbs_checker #(
        .count_width(count_width)
    ) checker_i (
        .clk_adc    (clk_adc),
        .cdr_rstb   (cdr_rstb),
        .check_en_i (check_en),
        .prbs_src_i (cfg_i.prbs_src),
        .adc_bits_i (code_word.bits),
        .bist_bits_i(bist_bits),
        .stats_o    (prbs_stats_o)
    );

endmodule

// ==== hdl/prbs_checker.sv ====
module prbs_checker #(
    parameter int count_width = 32
) (
    input  logic                              clk_adc,
    input  logic                              cdr_rstb,
    input  logic                              check_en_i,
    input  dcore_types_pkg::prbs_src_e        prbs_src_i,
    input  logic [dcore_const_pkg::n_ti-1:0]  adc_bits_i,
    input  logic [dcore_const_pkg::n_ti-1:0]  bist_bits_i,
    output dcore_types_pkg::prbs_stats_t      stats_o
);
    import dcore_const_pkg::*;
    import dcore_types_pkg::*;

    localparam int pop_w = $clog2(n_ti + 1);

    logic [n_ti-1:0]             rx_q;
    logic                        rx_en_q;
    logic [prbs_order-1:0]       hist_q;
    logic                        hist_ok_q;
    logic [n_ti+prbs_order-1:0]  ext;
    logic [n_ti-1:0]             err_bits;
    logic [pop_w-1:0]            err_pop;
    logic [count_width-1:0]      err_cnt_q;
    logic [count_width-1:0]      total_cnt_q;

    // first stage registers the chosen source
    always_ff @(posedge clk_adc) begin
        rx_q   <= (prbs_src_i == src_bist) ? bist_bits_i : adc_bits_i;
        hist_q <= rx_q[n_ti-1 -: prbs_order];
    end

    ////////////////////////////////////////
    // self-synchronizing prediction
    ////////////////////////////////////////

    // received history, so one flip hits three checks
    always_comb begin
        ext     = {rx_q, hist_q};
        err_pop = '0;
        for (int k = 0; k < n_ti; k++) begin
            err_bits[k] = rx_q[k] ^ ext[k] ^ ext[k + prbs_order - prbs_tap];
            err_pop     = err_pop + pop_w'(err_bits[k]);
        end
    end

    // the first enabled word only seeds the history
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            rx_en_q     <= 1'b0;
            hist_ok_q   <= 1'b0;
            err_cnt_q   <= '0;
            total_cnt_q <= '0;
        end else begin
            rx_en_q   <= check_en_i;
            hist_ok_q <= rx_en_q;
            if (rx_en_q && hist_ok_q) begin
                err_cnt_q   <= err_cnt_q + count_width'(err_pop);
                total_cnt_q <= total_cnt_q + count_width'(n_ti);
            end
        end
    end

    always_comb begin
        stats_o.err_count   = 32'(err_cnt_q);
        stats_o.total_count = 32'(total_cnt_q);
    end

endmodule

// ==== hdl/prbs_bist_gen.sv ====
module prbs_bist_gen (
    input  logic                              clk_adc,
    input  logic                              cdr_rstb,
    input  logic                              inj_err_i,
    output logic [dcore_const_pkg::n_ti-1:0]  bist_bits_o
);
    import dcore_const_pkg::*;

    // lfsr_q[0] holds the newest bit
    logic [prbs_order-1:0] lfsr_q;
    logic [prbs_order-1:0] lfsr_d;
    logic [n_ti-1:0]       word_d;

    // unroll n_ti steps, lane 0 first
    always_comb begin
        logic fb;
        fb     = 1'b0;
        lfsr_d = lfsr_q;
        for (int k = 0; k < n_ti; k++) begin
            fb        = lfsr_d[prbs_order-1] ^ lfsr_d[prbs_tap-1];
            word_d[k] = fb;
            lfsr_d    = {lfsr_d[prbs_order-2:0], fb};
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            lfsr_q <= prbs_seed;
        end else begin
            lfsr_q <= lfsr_d;
        end
    end

    // flip lane 0 only on the output, state stays clean
    always_ff @(posedge clk_adc) begin
        bist_bits_o <= word_d ^ {{(n_ti-1){1'b0}}, inj_err_i};
    end

endmodule

// ==== hdl/pi_code_map.sv ====
module pi_code_map (
    input  logic                                                          clk_adc,
    input  logic                                                          cdr_rstb,
    input  logic [dcore_const_pkg::n_pi-1:0]                              phase_i,
    input  logic [dcore_const_pkg::n_out-1:0][dcore_const_pkg::n_sel-1:0] max_sel_i,
    input  logic [dcore_const_pkg::n_out-1:0][dcore_const_pkg::n_pi-1:0]  pi_offset_i,
    output dcore_types_pkg::pi_ctl_t                                      pi_ctl_o
);
    import dcore_const_pkg::*;

    logic [n_out-1:0][n_pi-1:0] scale;
    logic [n_out-1:0][n_pi-1:0] fold_q;

    ////////////////////////////////////////
    // per-output wrap and offset
    ////////////////////////////////////////

    always_comb begin
        for (int j = 0; j < n_out; j++) begin
            // never zero, smallest wrap is scale_step-1
            scale[j] = (n_pi'(max_sel_i[j]) + 1'b1) * n_pi'(scale_step) - 1'b1;
            // offset is static config, added after the fold register
            pi_ctl_o.code[j] = fold_q[j] + pi_offset_i[j];
        end
    end

    // folded phase, zero in reset so outputs sit at their offsets
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            fold_q <= '0;
        end else begin
            for (int j = 0; j < n_out; j++) begin
                fold_q[j] <= phase_i % scale[j];
            end
        end
    end

endmodule

// ==== hdl/mm_cdr_loop.sv ====
module mm_cdr_loop (
    input  logic                                 clk_adc,
    input  logic                                 cdr_rstb,
    input  dcore_types_pkg::code_word_t          code_word_i,
    input  logic                                 loop_en_i,
    input  logic [3:0]                           loop_shift_i,
    output logic [dcore_const_pkg::n_pi-1:0]     phase_o
);
    import dcore_const_pkg::*;

    localparam int code_w = n_adc + 1;
    // two products per lane, summed over all lanes
    localparam int sum_w = code_w + 2 + $clog2(n_ti);

    logic signed [code_w-1:0]  prev_code;
    logic                      prev_bit;
    logic signed [sum_w-1:0]   pd_sum;
    logic signed [sum_w-1:0]   pd_step;

    // d is +1 for a one and -1 for a zero
    function automatic logic signed [sum_w-1:0] times_bit(
        input logic signed [code_w-1:0] c,
        input logic                     d
    );
        logic signed [sum_w-1:0] c_ext;
        c_ext = c;
        return d ? c_ext : -c_ext;
    endfunction

    ////////////////////////////////////////
    // Mueller-Muller phase detector
    ////////////////////////////////////////

    always_comb begin
        logic signed [code_w-1:0] c_prev;
        logic signed [code_w-1:0] c_cur;
        logic                     d_prev;
        logic                     d_cur;
        pd_sum = '0;
        c_prev = prev_code;
        d_prev = prev_bit;
        for (int k = 0; k < n_ti; k++) begin
            c_cur  = $signed(code_word_i.code[k]);
            d_cur  = code_word_i.bits[k];
            pd_sum = pd_sum + times_bit(c_cur, d_prev) - times_bit(c_prev, d_cur);
            c_prev = c_cur;
            d_prev = d_cur;
        end
    end

    // loop gain as a power of two
    assign pd_step = pd_sum >>> loop_shift_i;

    // integrator wraps naturally at 2^n_pi
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            prev_code <= '0;
            prev_bit  <= 1'b0;
            phase_o   <= '0;
        end else begin
            // last lane becomes lane -1 of the next word
            prev_code <= $signed(code_word_i.code[n_ti-1]);
            prev_bit  <= code_word_i.bits[n_ti-1];
            if (loop_en_i) begin
                phase_o <= phase_o + pd_step[n_pi-1:0];
            end
        end
    end

endmodule

// ==== hdl/adc_unfold.sv ====
module adc_unfold (
    input  logic                         clk_adc,
    input  logic                         cdr_rstb,
    input  dcore_types_pkg::adc_word_t   adc_word_i,
    output dcore_types_pkg::code_word_t  code_word_o
);
    import dcore_const_pkg::*;
    import dcore_types_pkg::*;

    code_word_t unfolded;

    ////////////////////////////////////////
    // sign-magnitude to two's complement
    ////////////////////////////////////////

    // sign low means a negative sample
    always_comb begin
        for (int k = 0; k < n_ti; k++) begin
            if (adc_word_i.sign[k]) begin
                unfolded.code[k] = {1'b0, adc_word_i.mag[k]};
            end else begin
                unfolded.code[k] = -{1'b0, adc_word_i.mag[k]};
            end
            // slicer decision is just the sign
            unfolded.bits[k] = adc_word_i.sign[k];
        end
    end

    // one retiming stage ahead of the loop
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            code_word_o <= '0;
        end else begin
            code_word_o <= unfolded;
        end
    end

endmodule

// ==== hdl/dcore_ctrl.sv ====
module dcore_ctrl #(
    parameter int settle_cycles = 32
) (
    input  logic clk_adc,
    input  logic cdr_rstb,
    output logic ctl_valid_o,
    output logic loop_en_o,
    output logic check_en_o
);
    import dcore_types_pkg::*;

    localparam int cnt_w = (settle_cycles > 1) ? $clog2(settle_cycles) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(settle_cycles - 1);

    ctrl_state_e       state;
    logic [cnt_w-1:0]  settle_cnt;

    // wait out the settling window once per reset
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state      <= st_settle;
            settle_cnt <= '0;
        end else begin
            case (state)
                st_settle: begin
                    if (settle_cnt == cnt_last) begin
                        state <= st_run;
                    end else begin
                        settle_cnt <= settle_cnt + 1'b1;
                    end
                end
                // run is held until the next reset
                default: begin
                    state <= st_run;
                end
            endcase
        end
    end

    // loop and checker start together with valid
    always_comb begin
        ctl_valid_o = (state == st_run);
        loop_en_o   = (state == st_run);
        check_en_o  = (state == st_run);
    end

endmodule

// ==== hdl/dcore_types_pkg.sv ====
package dcore_types_pkg;

    import dcore_const_pkg::*;

    ////////////////////////////////////////
    // opcodes and states
    ////////////////////////////////////////

    // bit source feeding the checker
    typedef enum logic {
        src_adc  = 1'b0,
        src_bist = 1'b1
    } prbs_src_e;

    typedef enum logic {
        st_settle = 1'b0,
        st_run    = 1'b1
    } ctrl_state_e;

    ////////////////////////////////////////
    // datapath words
    ////////////////////////////////////////

    // raw sign-magnitude word from the ADC, lane 0 earliest
    typedef struct packed {
        logic [n_ti-1:0][n_adc-1:0] mag;
        logic [n_ti-1:0]            sign;
    } adc_word_t;

    // two's complement codes, one extra bit for the sign
    typedef struct packed {
        logic [n_ti-1:0][n_adc:0] code;
        logic [n_ti-1:0]          bits;
    } code_word_t;

    // static configuration, held steady while running
    typedef struct packed {
        logic [3:0]                  loop_shift;
        prbs_src_e                   prbs_src;
        logic [n_out-1:0][n_sel-1:0] max_sel;
        logic [n_out-1:0][n_pi-1:0]  pi_offset;
    } dcore_cfg_t;

    typedef struct packed {
        logic [n_out-1:0][n_pi-1:0] code;
    } pi_ctl_t;

    typedef struct packed {
        logic [31:0] err_count;
        logic [31:0] total_count;
    } prbs_stats_t;

endpackage

// ==== hdl/dcore_const_pkg.sv ====
package dcore_const_pkg;

    ////////////////////////////////////////
    // lane and datapath widths
    ////////////////////////////////////////

    // interleaved ADC slices per clk_adc cycle
    localparam int n_ti = 16;

    // magnitude bits of one slice, sign travels separately
    localparam int n_adc = 8;

    // phase interpolator code width
    localparam int n_pi = 9;

    // number of PI control outputs
    localparam int n_out = 4;

    // per-output scale select
    localparam int n_sel = 4;

    ////////////////////////////////////////
    // prbs polynomial x^7 + x^6 + 1
    ////////////////////////////////////////

    localparam int prbs_order = 7;

    // second feedback tap
    localparam int prbs_tap = 6;

    // generator start state, any nonzero value works
    localparam logic [prbs_order-1:0] prbs_seed = {prbs_order{1'b1}};

    // granularity of the PI wrap point
    localparam int scale_step = 16;

endpackage
